/* rtl/offload_pkg.sv */
// Shared widths and enums for the offload hub
// Instruction field positions and config address split

package offload_pkg;

  // Datapath widths
  localparam int unsigned DATA_WIDTH       = 32;
  localparam int unsigned INSTR_WIDTH      = 32;
  localparam int unsigned ID_WIDTH_DEFAULT = 5;

  // ----------------------------------------
  // Instruction word fields
  // ----------------------------------------
  localparam int unsigned OPC_WIDTH = 4;
  localparam int unsigned IMM_LSB   = 20;
  localparam int unsigned IMM_MSB   = 31;

  // Config address split with the mover index in the low bits
  localparam int unsigned MOVER_FIELD_WIDTH = 5;
  localparam int unsigned REG_FIELD_WIDTH   = 7;
  localparam int unsigned CFG_ADDR_WIDTH    = MOVER_FIELD_WIDTH + REG_FIELD_WIDTH;

  // Target execution unit
  typedef enum logic {
    UNIT_SSR_CFG = 1'b0,
    UNIT_IPU     = 1'b1
  } acc_unit_e;

  // Decoded operations
  typedef enum logic [OPC_WIDTH-1:0] {
    OP_SCFGR   = 4'd0,
    OP_SCFGW   = 4'd1,
    OP_SCFGRI  = 4'd2,
    OP_SCFGWI  = 4'd3,
    OP_ADD     = 4'd4,
    OP_SUB     = 4'd5,
    OP_MUL     = 4'd6,
    OP_MINU    = 4'd7,
    OP_ILLEGAL = 4'd15
  } op_e;

endpackage

/* rtl/offload_intf.sv */
// Decoded request and unit response interfaces
// Both carry a valid/ready handshake

`timescale 1ns/1ns

interface dec_req_if #(
  parameter int unsigned IdWidth = offload_pkg::ID_WIDTH_DEFAULT
);
  import offload_pkg::*;

  logic                      valid;
  logic                      ready;
  logic [IdWidth-1:0]        id;
  op_e                       op;
  logic [DATA_WIDTH-1:0]     arga;
  logic [DATA_WIDTH-1:0]     argb;
  // Reordered as mover index then register index
  logic [CFG_ADDR_WIDTH-1:0] cfg_word;

  modport src (output valid, id, op, arga, argb, cfg_word, input ready);
  modport dst (input valid, id, op, arga, argb, cfg_word, output ready);
endinterface

interface unit_rsp_if #(
  parameter int unsigned IdWidth = offload_pkg::ID_WIDTH_DEFAULT
);
  import offload_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [IdWidth-1:0]    id;
  logic [DATA_WIDTH-1:0] data;
  logic                  error;

  modport src (output valid, id, data, error, input ready);
  modport dst (input valid, id, data, error, output ready);
endinterface

/* rtl/offload_decode.sv */
// Offload request decode stage
// Classifies by target unit, builds config words, holds one request

`timescale 1ns/1ns

module offload_decode #(
  parameter int unsigned IdWidth = offload_pkg::ID_WIDTH_DEFAULT
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [IdWidth-1:0]                  req_id_i,
  input  offload_pkg::acc_unit_e              req_unit_i,
  input  logic [offload_pkg::INSTR_WIDTH-1:0] req_instr_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  req_arga_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  req_argb_i,
  dec_req_if.src                              cfg_o,
  dec_req_if.src                              ipu_o
);
  import offload_pkg::*;

  logic [OPC_WIDTH-1:0]      opc;
  op_e                       op_d;
  logic [CFG_ADDR_WIDTH-1:0] addr;
  logic [CFG_ADDR_WIDTH-1:0] cfg_word_d;
  logic [IdWidth-1:0]        id_d;
  logic                      out_ready;
  logic                      accept;

  logic                      valid_q;
  acc_unit_e                 unit_q;
  logic [IdWidth-1:0]        id_q;
  op_e                       op_q;
  logic [DATA_WIDTH-1:0]     arga_q;
  logic [DATA_WIDTH-1:0]     argb_q;
  logic [CFG_ADDR_WIDTH-1:0] cfg_word_q;

  assign opc = req_instr_i[OPC_WIDTH-1:0];

  // Codes outside the selected unit's set become illegal
  always_comb begin
    op_d = OP_ILLEGAL;
    case (req_unit_i)
      UNIT_SSR_CFG: begin
        if (opc inside {OP_SCFGR, OP_SCFGW, OP_SCFGRI, OP_SCFGWI}) begin
          op_d = op_e'(opc);
        end
      end
      UNIT_IPU: begin
        if (opc inside {OP_ADD, OP_SUB, OP_MUL, OP_MINU}) begin
          op_d = op_e'(opc);
        end
      end
      default: ;
    endcase
  end

  // Immediate forms take the address from the instruction
  always_comb begin
    addr = '0;
    case (op_d)
      OP_SCFGRI, OP_SCFGWI: addr = req_instr_i[IMM_MSB:IMM_LSB];
      OP_SCFGR, OP_SCFGW:   addr = req_argb_i[CFG_ADDR_WIDTH-1:0];
      default: ;
    endcase
  end

  assign cfg_word_d = {addr[MOVER_FIELD_WIDTH-1:0], addr[CFG_ADDR_WIDTH-1:MOVER_FIELD_WIDTH]};

  // Writes carry id zero so the core writes nothing back
  assign id_d = (op_d inside {OP_SCFGW, OP_SCFGWI}) ? '0 : req_id_i;

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  assign out_ready   = (unit_q == UNIT_IPU) ? ipu_o.ready : cfg_o.ready;
  assign req_ready_o = ~valid_q | out_ready;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      unit_q  <= UNIT_SSR_CFG;
    end else if (accept) begin
      valid_q <= 1'b1;
      unit_q  <= req_unit_i;
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q       <= id_d;
      op_q       <= op_d;
      arga_q     <= req_arga_i;
      argb_q     <= req_argb_i;
      cfg_word_q <= cfg_word_d;
    end
  end

  // Payload fans out to both units and valid only to the selected one
  assign cfg_o.valid    = valid_q & (unit_q == UNIT_SSR_CFG);
  assign cfg_o.id       = id_q;
  assign cfg_o.op       = op_q;
  assign cfg_o.arga     = arga_q;
  assign cfg_o.argb     = argb_q;
  assign cfg_o.cfg_word = cfg_word_q;

  assign ipu_o.valid    = valid_q & (unit_q == UNIT_IPU);
  assign ipu_o.id       = id_q;
  assign ipu_o.op       = op_q;
  assign ipu_o.arga     = arga_q;
  assign ipu_o.argb     = argb_q;
  assign ipu_o.cfg_word = cfg_word_q;

endmodule

/* rtl/ssr_cfg_regs.sv */
// Stream configuration register file unit
// Answers every access with the old value, then applies writes

`timescale 1ns/1ns

module ssr_cfg_regs #(
  parameter int unsigned NumMovers = 2,
  parameter int unsigned NumRegs   = 8
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  dec_req_if.dst  req_i,
  unit_rsp_if.src rsp_o
);
  import offload_pkg::*;

  localparam int unsigned NumWords = NumMovers * NumRegs;
  localparam int unsigned WordIdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic [MOVER_FIELD_WIDTH-1:0] mover_idx;
  logic [REG_FIELD_WIDTH-1:0]   reg_idx;
  logic                         in_range;
  logic [WordIdxW-1:0]          word_idx;
  logic                         is_write;
  logic                         illegal;
  logic [DATA_WIDTH-1:0]        rdata;
  logic                         accept;
  logic                         valid_q;
  logic [DATA_WIDTH-1:0]        regs_q [NumWords];

  // Word is mover index on top of register index
  assign mover_idx = req_i.cfg_word[CFG_ADDR_WIDTH-1 -: MOVER_FIELD_WIDTH];
  assign reg_idx   = req_i.cfg_word[REG_FIELD_WIDTH-1:0];
  assign in_range  = (32'(mover_idx) < NumMovers) && (32'(reg_idx) < NumRegs);
  assign word_idx  = WordIdxW'(32'(mover_idx) * NumRegs + 32'(reg_idx));

  assign is_write = (req_i.op == OP_SCFGW) || (req_i.op == OP_SCFGWI);
  assign illegal  = !(req_i.op inside {OP_SCFGR, OP_SCFGW, OP_SCFGRI, OP_SCFGWI});

  // Out of range reads as zero
  assign rdata = in_range ? regs_q[word_idx] : '0;

  assign req_i.ready = ~valid_q | rsp_o.ready;
  assign accept      = req_i.valid & req_i.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NumWords; i++) begin
        regs_q[i] <= '0;
      end
    end else if (accept && is_write && in_range) begin
      regs_q[word_idx] <= req_i.arga;
    end
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (rsp_o.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_o.id    <= req_i.id;
      rsp_o.data  <= illegal ? '0 : rdata;
      rsp_o.error <= illegal;
    end
  end

  assign rsp_o.valid = valid_q;

endmodule

/* rtl/int_unit.sv */
// Private integer unit
// Add, subtract, multiply low and unsigned minimum with one result register

`timescale 1ns/1ns

module int_unit (
  input  logic    clk_i,
  input  logic    rst_ni,
  dec_req_if.dst  req_i,
  unit_rsp_if.src rsp_o
);
  import offload_pkg::*;

  logic [DATA_WIDTH-1:0] result;
  logic                  illegal;
  logic                  accept;
  logic                  valid_q;

  // All results wrap modulo 2^32
  always_comb begin
    result  = '0;
    illegal = 1'b0;
    case (req_i.op)
      OP_ADD:  result = req_i.arga + req_i.argb;
      OP_SUB:  result = req_i.arga - req_i.argb;
      OP_MUL:  result = req_i.arga * req_i.argb;
      OP_MINU: result = (req_i.arga < req_i.argb) ? req_i.arga : req_i.argb;
      default: illegal = 1'b1;
    endcase
  end

  assign req_i.ready = ~valid_q | rsp_o.ready;
  assign accept      = req_i.valid & req_i.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (rsp_o.ready) begin
      valid_q <= 1'b0;
    end
  end

  // Result travels with the request id
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_o.id    <= req_i.id;
      rsp_o.data  <= result;
      rsp_o.error <= illegal;
    end
  end

  assign rsp_o.valid = valid_q;

endmodule

/* rtl/resp_arbiter.sv */
// Round-robin arbiter for the two unit response streams
// Grant stays locked while a response waits on the core

`timescale 1ns/1ns

module resp_arbiter #(
  parameter int unsigned IdWidth = offload_pkg::ID_WIDTH_DEFAULT
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  unit_rsp_if.dst                            cfg_i,
  unit_rsp_if.dst                            ipu_i,
  output logic                               rsp_valid_o,
  input  logic                               rsp_ready_i,
  output logic [IdWidth-1:0]                 rsp_id_o,
  output logic [offload_pkg::DATA_WIDTH-1:0] rsp_data_o,
  output logic                               rsp_error_o
);
  import offload_pkg::*;

  acc_unit_e last_q;
  acc_unit_e gnt_q;
  logic      lock_q;
  acc_unit_e rr_gnt;
  acc_unit_e gnt;
  logic      xfer;

  // Prefer the input that lost last time
  always_comb begin
    if (cfg_i.valid && ipu_i.valid) begin
      rr_gnt = (last_q == UNIT_SSR_CFG) ? UNIT_IPU : UNIT_SSR_CFG;
    end else if (ipu_i.valid) begin
      rr_gnt = UNIT_IPU;
    end else begin
      rr_gnt = UNIT_SSR_CFG;
    end
  end

  // Hold an offered response stable until it is taken
  assign gnt = lock_q ? gnt_q : rr_gnt;

  assign rsp_valid_o = (gnt == UNIT_IPU) ? ipu_i.valid : cfg_i.valid;
  assign rsp_id_o    = (gnt == UNIT_IPU) ? ipu_i.id    : cfg_i.id;
  assign rsp_data_o  = (gnt == UNIT_IPU) ? ipu_i.data  : cfg_i.data;
  assign rsp_error_o = (gnt == UNIT_IPU) ? ipu_i.error : cfg_i.error;

  assign cfg_i.ready = rsp_ready_i & (gnt == UNIT_SSR_CFG);
  assign ipu_i.ready = rsp_ready_i & (gnt == UNIT_IPU);

  assign xfer = rsp_valid_o & rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= UNIT_IPU;
      gnt_q  <= UNIT_SSR_CFG;
      lock_q <= 1'b0;
    end else begin
      lock_q <= rsp_valid_o & ~rsp_ready_i;
      gnt_q  <= gnt;
      if (xfer) begin
        last_q <= gnt;
      end
    end
  end

endmodule

/* rtl/offload_cc.sv */
// Offload hub top level
// Decode, config register unit, integer unit and response arbiter

`timescale 1ns/1ns

module offload_cc #(
  parameter int unsigned IdWidth   = offload_pkg::ID_WIDTH_DEFAULT,
  parameter int unsigned NumMovers = 2,
  parameter int unsigned NumRegs   = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Request from the core
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [IdWidth-1:0]                  req_id_i,
  input  offload_pkg::acc_unit_e              req_unit_i,
  input  logic [offload_pkg::INSTR_WIDTH-1:0] req_instr_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  req_arga_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  req_argb_i,
  // Response to the core
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output logic [IdWidth-1:0]                  rsp_id_o,
  output logic [offload_pkg::DATA_WIDTH-1:0]  rsp_data_o,
  output logic                                rsp_error_o
);

  dec_req_if  #(.IdWidth(IdWidth)) cfg_req ();
  dec_req_if  #(.IdWidth(IdWidth)) ipu_req ();
  unit_rsp_if #(.IdWidth(IdWidth)) cfg_rsp ();
  unit_rsp_if #(.IdWidth(IdWidth)) ipu_rsp ();

  offload_decode #(
    .IdWidth (IdWidth)
  ) i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_id_i    (req_id_i),
    .req_unit_i  (req_unit_i),
    .req_instr_i (req_instr_i),
    .req_arga_i  (req_arga_i),
    .req_argb_i  (req_argb_i),
    .cfg_o       (cfg_req),
    .ipu_o       (ipu_req)
  );

  ssr_cfg_regs #(
    .NumMovers (NumMovers),
    .NumRegs   (NumRegs)
  ) i_ssr_cfg_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (cfg_req),
    .rsp_o  (cfg_rsp)
  );

  int_unit i_int_unit (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (ipu_req),
    .rsp_o  (ipu_rsp)
  );

  resp_arbiter #(
    .IdWidth (IdWidth)
  ) i_resp_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg_rsp),
    .ipu_i       (ipu_rsp),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_error_o (rsp_error_o)
  );

endmodule

/* verification/tb_offload_cc.sv */
// Testbench for the offload hub
// Clock, LCG stimulus, reference model, response checker and watchdog

`timescale 1ns/1ns

module tb_offload_cc;
  import offload_pkg::*;

  localparam int unsigned NumReq    = 628;
  localparam int unsigned TimeoutNs = 4 * NumReq * 8 + 2000;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        req_valid_i;
  logic                        req_ready_o;
  logic [ID_WIDTH_DEFAULT-1:0] req_id_i;
  acc_unit_e                   req_unit_i;
  logic [INSTR_WIDTH-1:0]      req_instr_i;
  logic [DATA_WIDTH-1:0]       req_arga_i;
  logic [DATA_WIDTH-1:0]       req_argb_i;
  logic                        rsp_valid_o;
  logic                        rsp_ready_i;
  logic [ID_WIDTH_DEFAULT-1:0] rsp_id_o;
  logic [DATA_WIDTH-1:0]       rsp_data_o;
  logic                        rsp_error_o;

  // Model state and expected responses as {error, data}
  logic [31:0] cfg_model [16];
  logic [32:0] exp_rsp [32];
  logic        pend [32];
  logic [32:0] write_q [$];
  logic [32:0] rsp_exp;
  int          outstanding;
  int          errors;
  int          checks;
  int          test_base;
  logic [4:0]  next_id;
  logic [31:0] lcg_state;
  logic        bp_en;
  logic [31:0] bp_rand;

  offload_cc #(
    .IdWidth   (ID_WIDTH_DEFAULT),
    .NumMovers (2),
    .NumRegs   (8)
  ) DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_id_i    (req_id_i),
    .req_unit_i  (req_unit_i),
    .req_instr_i (req_instr_i),
    .req_arga_i  (req_arga_i),
    .req_argb_i  (req_argb_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_id_o    (rsp_id_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_error_o (rsp_error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Build each word from the upper halves of two LCG steps
  function automatic logic [31:0] rand32();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return rand32() % n;
  endfunction

  // Register index on top of the 5-bit mover index
  function automatic logic [11:0] cfg_addr(input int unsigned mov, input int unsigned rg);
    return {rg[6:0], mov[4:0]};
  endfunction

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [32:0] ref_response(input acc_unit_e unit, input logic [31:0] instr,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [3:0]  opc;
    logic [11:0] addr;
    int unsigned idx;
    logic [31:0] old;
    opc = instr[3:0];
    if (unit == UNIT_IPU) begin
      case (opc)
        4'd4:    return {1'b0, a + b};
        4'd5:    return {1'b0, a - b};
        4'd6:    return {1'b0, a * b};
        4'd7:    return {1'b0, (a < b) ? a : b};
        default: return {1'b1, 32'h0};
      endcase
    end
    if (opc > 4'd3) begin
      return {1'b1, 32'h0};
    end
    // Immediate forms carry the address in the top 12 bits
    addr = opc[1] ? instr[31:20] : b[11:0];
    if (addr[4:0] > 5'd1 || addr[11:5] > 7'd7) begin
      return {1'b0, 32'h0};
    end
    idx = 32'(addr[4:0]) * 32'd8 + 32'(addr[11:5]);
    old = cfg_model[idx];
    if (opc[0]) begin
      cfg_model[idx] = a;
    end
    return {1'b0, old};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] gotv);
    if (gotv !== expv) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, expv, gotv);
      errors++;
    end
  endtask

  // Drive one request and hold it until the hub takes it
  task automatic issue(input acc_unit_e unit, input logic [3:0] opc, input logic [11:0] imm,
                       input logic [31:0] a, input logic [31:0] b);
    logic [31:0] instr;
    logic [32:0] expv;
    logic        accepted;
    logic        is_write;
    instr = rand32();
    instr = {imm, instr[19:4], opc};
    is_write = (unit == UNIT_SSR_CFG) && (opc == 4'd1 || opc == 4'd3);
    if (pend[next_id]) begin
      req_valid_i = 1'b0;
      while (pend[next_id]) begin
        @(posedge clk_i);
        #1;
      end
    end
    expv = ref_response(unit, instr, a, b);
    // Writes come back with id 0 in issue order
    if (is_write) begin
      write_q.push_back(expv);
    end else begin
      exp_rsp[next_id] = expv;
      pend[next_id]    = 1'b1;
    end
    outstanding++;
    req_valid_i = 1'b1;
    req_id_i    = next_id;
    req_unit_i  = unit;
    req_instr_i = instr;
    req_arga_i  = a;
    req_argb_i  = b;
    next_id = (next_id == 5'd31) ? 5'd1 : next_id + 5'd1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic cfg_access(input logic [3:0] opc, input logic [11:0] addr);
    logic [31:0] b;
    b = rand32();
    if (opc[1]) begin
      issue(UNIT_SSR_CFG, opc, addr, rand32(), b);
    end else begin
      b[11:0] = addr;
      issue(UNIT_SSR_CFG, opc, 12'(rand32()), rand32(), b);
    end
  endtask

  task automatic cfg_sweep(input logic [3:0] opc);
    for (int unsigned m = 0; m < 2; m++) begin
      for (int unsigned r = 0; r < 8; r++) begin
        cfg_access(opc, cfg_addr(m, r));
      end
    end
  endtask

  task automatic finish_test(input string name);
    while (outstanding != 0) begin
      @(posedge clk_i);
      #1;
    end
    $display("%s finished with %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // ----------------------------------------
  // Response checker at the falling edge
  // ----------------------------------------
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && rsp_valid_o && rsp_ready_i) begin
        checks++;
        if (rsp_id_o == '0) begin
          if (write_q.size() == 0) begin
            $display("Write response at %0t arrived with no write outstanding", $time);
            errors++;
          end else begin
            rsp_exp = write_q.pop_front();
            check_value("rsp_data_o", rsp_exp[31:0], rsp_data_o);
            check_value("rsp_error_o", 32'(rsp_exp[32]), 32'(rsp_error_o));
            outstanding--;
          end
        end else if (!pend[rsp_id_o]) begin
          $display("Response with id %0d at %0t was not expected", rsp_id_o, $time);
          errors++;
        end else begin
          rsp_exp = exp_rsp[rsp_id_o];
          pend[rsp_id_o] = 1'b0;
          check_value("rsp_data_o", rsp_exp[31:0], rsp_data_o);
          check_value("rsp_error_o", 32'(rsp_exp[32]), 32'(rsp_error_o));
          outstanding--;
        end
      end
    end
  end

  // Random back-pressure on the response port
  initial begin
    rsp_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      bp_rand = lcg_next();
      #1;
      rsp_ready_i = bp_en ? bp_rand[31] : 1'b1;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [3:0]  c;
    logic [11:0] addr;
    lcg_state   = 32'd12;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_id_i    = '0;
    req_unit_i  = UNIT_SSR_CFG;
    req_instr_i = '0;
    req_arga_i  = '0;
    req_argb_i  = '0;
    bp_en       = 1'b0;
    errors      = 0;
    checks      = 0;
    test_base   = 0;
    outstanding = 0;
    next_id     = 5'd1;
    for (int i = 0; i < 32; i++) begin
      pend[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      cfg_model[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    check_value("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
    check_value("req_ready_o", 32'd1, 32'(req_ready_o));
    @(posedge clk_i);
    #1;
    finish_test("reset");

    cfg_sweep(OP_SCFGRI);
    cfg_sweep(OP_SCFGW);
    cfg_sweep(OP_SCFGR);
    cfg_sweep(OP_SCFGWI);
    finish_test("config write and read");

    cfg_sweep(OP_SCFGW);
    finish_test("write responses");

    repeat (200) begin
      issue(UNIT_IPU, 4'(32'd4 + pick(4)), 12'(rand32()), rand32(), rand32());
    end
    finish_test("integer ops");

    // Illegal codes on both units and then out-of-range addresses
    for (int unsigned k = 0; k < 16; k++) begin
      if (k[0]) begin
        c = 4'(pick(12));
        if (c > 4'd3) begin
          c = c + 4'd4;
        end
        issue(UNIT_IPU, c, 12'(rand32()), rand32(), rand32());
      end else begin
        issue(UNIT_SSR_CFG, 4'(32'd4 + pick(12)), 12'(rand32()), rand32(), rand32());
      end
    end
    for (int unsigned k = 0; k < 16; k++) begin
      addr = k[0] ? cfg_addr(32'd2 + pick(30), pick(8)) : cfg_addr(pick(2), 32'd8 + pick(120));
      if (k < 8) begin
        cfg_access(k[1] ? OP_SCFGWI : OP_SCFGW, addr);
      end else begin
        cfg_access(k[1] ? OP_SCFGRI : OP_SCFGR, addr);
      end
    end
    cfg_sweep(OP_SCFGR);
    finish_test("errors");

    bp_en = 1'b1;
    repeat (300) begin
      if (pick(2) == 0) begin
        c = 4'(32'd4 + pick(4));
        if (pick(16) == 0) begin
          c = 4'hf;
        end
        issue(UNIT_IPU, c, 12'(rand32()), rand32(), rand32());
      end else begin
        c = 4'(pick(4));
        if (pick(16) == 0) begin
          c = 4'h9;
        end
        cfg_access(c, cfg_addr(pick(2), pick(8)));
      end
    end
    finish_test("mixed traffic");
    bp_en = 1'b0;

    $display("Summary: %0d responses checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* offload_cc.f */
rtl/offload_pkg.sv
rtl/offload_intf.sv
rtl/offload_decode.sv
rtl/ssr_cfg_regs.sv
rtl/int_unit.sv
rtl/resp_arbiter.sv
rtl/offload_cc.sv
verification/tb_offload_cc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the offload hub testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f offload_cc.f --top-module tb_offload_cc \
  --Mdir obj_dir -o Vtb_offload_cc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_offload_cc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  exit 0
fi
exit 1
